// File: logic/video_config.svh
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

//////////////////////////////////////////////////
// Horizontal timing, in pixels
//////////////////////////////////////////////////
`define H_TOTAL         800
`define H_ACTIVE        640
`define H_SYNC_START    656
`define H_SYNC_LEN      96

//////////////////////////////////////////////////
// Vertical timing, in scan lines
//////////////////////////////////////////////////
`define V_TOTAL         525
`define V_ACTIVE        480
`define V_SYNC_START    490
`define V_SYNC_LEN      2

// Text area in doubled lines
`define BORDER_TOP      16
`define BORDER_BOTTOM   216

//////////////////////////////////////////////////
// Memory sizes
//////////////////////////////////////////////////
// Text RAM, 2048 cells of char and colour
`define TRAM_AW         11
// Glyph RAM, 256 glyphs of 8 rows
`define CHRAM_AW        11

`endif

// File: logic/video_pkg.sv
`include "video_config.svh"

package video_pkg;

    // Destination of a CPU write
    typedef enum logic [1:0] {
        TGT_TEXT    = 2'd0,
        TGT_GLYPH   = 2'd1,
        TGT_PALETTE = 2'd2
    } vid_target_e;

    typedef enum logic {
        COLS_40 = 1'b0,
        COLS_80 = 1'b1
    } col_mode_e;

    // One write from the CPU side
    typedef struct packed {
        vid_target_e          target;
        logic [`TRAM_AW-1:0]  addr;
        logic [15:0]          data;
        logic                 wren;
    } cpu_write_t;

    // Raster position and sync state
    typedef struct packed {
        logic [9:0] hpos;
        logic [7:0] line;       // 255 outside the visible lines
        logic       hsync;
        logic       vsync;
        logic       blank;
        logic       vborder;
        logic       line_start; // Last pixel of each scan line
        logic       vblank;
        logic       newframe;
        logic       oddline;
    } vtiming_t;

    // Text stage result with its sync bits
    typedef struct packed {
        logic [3:0] colidx;
        logic       hsync;
        logic       vsync;
        logic       blank;
        logic       border;
    } text_pixel_t;

endpackage

// File: logic/dp_ram.sv
module dp_ram #(
    parameter int ADDR_W = 11,
    parameter int DATA_W = 16
) (
    input  logic              vclk,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [DATA_W-1:0] rd_data
);

    logic [DATA_W-1:0] mem [2**ADDR_W];

    // CPU side write port
    always_ff @(posedge vclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Video side read, one cycle latency
    always_ff @(posedge vclk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: logic/video_timing.sv
`include "video_config.svh"

module video_timing (
    input  logic                vclk,
    input  logic                rst_n,
    output video_pkg::vtiming_t raster
);
    import video_pkg::*;

    localparam logic [9:0] H_LAST   = 10'(`H_TOTAL - 1);
    localparam logic [9:0] V_LAST   = 10'(`V_TOTAL - 1);
    localparam logic [9:0] H_ACT    = 10'(`H_ACTIVE);
    localparam logic [9:0] V_ACT    = 10'(`V_ACTIVE);
    localparam logic [9:0] HS_START = 10'(`H_SYNC_START);
    localparam logic [9:0] HS_END   = 10'(`H_SYNC_START + `H_SYNC_LEN);
    localparam logic [9:0] VS_START = 10'(`V_SYNC_START);
    localparam logic [9:0] VS_END   = 10'(`V_SYNC_START + `V_SYNC_LEN);
    localparam logic [7:0] B_TOP    = 8'(`BORDER_TOP);
    localparam logic [7:0] B_BOT    = 8'(`BORDER_BOTTOM);

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic [7:0] line_d;
    vtiming_t   raster_d;

    //////////////////////////////////////////////////
    // Pixel and line counters
    //////////////////////////////////////////////////
    always_ff @(posedge vclk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? 10'd0 : v_cnt + 10'd1;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    //////////////////////////////////////////////////
    // Position decode
    //////////////////////////////////////////////////
    always_comb begin
        // Two scan lines per text line
        line_d = (v_cnt >= V_ACT) ? 8'hff : v_cnt[8:1];

        raster_d.hpos       = h_cnt;
        raster_d.line       = line_d;
        raster_d.hsync      = (h_cnt >= HS_START) && (h_cnt < HS_END);
        raster_d.vsync      = (v_cnt >= VS_START) && (v_cnt < VS_END);
        raster_d.blank      = (h_cnt >= H_ACT) || (v_cnt >= V_ACT);
        raster_d.vborder    = (line_d < B_TOP) || (line_d >= B_BOT);
        raster_d.line_start = (h_cnt == H_LAST);
        raster_d.vblank     = (v_cnt >= V_ACT);
        raster_d.newframe   = (h_cnt == 10'd0) && (v_cnt == 10'd0);
        raster_d.oddline    = v_cnt[0];
    end

    // All raster fields leave on a register
    always_ff @(posedge vclk) begin
        if (!rst_n) begin
            raster <= '0;
        end else begin
            raster <= raster_d;
        end
    end

    // Decoded position stays inside the line
    a_hpos_range: assert property (
        @(posedge vclk) disable iff (!rst_n)
        raster.hpos <= H_LAST
    );

endmodule

// File: logic/text_fetch.sv
`include "video_config.svh"

module text_fetch (
    input  logic                   vclk,
    input  logic                   rst_n,
    input  video_pkg::vtiming_t    raster,
    input  video_pkg::cpu_write_t  cpu_wr,
    input  logic                   mode_80,
    output video_pkg::text_pixel_t text_pix
);
    import video_pkg::*;

    localparam int TAW = `TRAM_AW;
    localparam int CAW = `CHRAM_AW;

    col_mode_e          col_mode;
    logic [TAW-1:0]     row_base;
    logic [TAW-1:0]     row_step;
    logic [TAW-1:0]     char_addr_q;
    logic [TAW-1:0]     char_addr_d;
    logic               border;
    logic               border_q;
    logic               start_active;
    logic               next_char;
    logic               next_row;

    logic               tram_we;
    logic               chram_we;
    logic [15:0]        cell_q1;
    logic [CAW-1:0]     glyph_addr;
    logic [7:0]         glyph_q2;

    logic [2:0]         line_q1;
    logic [3:0]         hpos_q1;
    logic [3:0]         hpos_q2;
    logic [7:0]         colour_q2;
    logic [3:0]         ctl_q1;
    logic [3:0]         ctl_q2;
    logic [2:0]         pix_sel;
    logic               glyph_bit;

    //////////////////////////////////////////////////
    // Row base and column mode
    //////////////////////////////////////////////////
    assign row_step = (col_mode == COLS_80) ? TAW'(80) : TAW'(40);

    // Advance after the second scan of every eighth text line
    assign next_row = raster.line_start && raster.oddline && !raster.vborder
                      && (raster.line[2:0] == 3'd7);

    always_ff @(posedge vclk) begin
        if (!rst_n) begin
            col_mode <= COLS_40;
            row_base <= '0;
        end else if (raster.vblank) begin
            col_mode <= mode_80 ? COLS_80 : COLS_40;
            row_base <= '0;
        end else if (next_row) begin
            row_base <= row_base + row_step;
        end
    end

    //////////////////////////////////////////////////
    // Character address
    //////////////////////////////////////////////////
    assign border       = raster.vborder || raster.blank;
    assign start_active = border_q && !border;
    assign next_char    = (col_mode == COLS_80) ? (raster.hpos[2:0] == 3'd0)
                                                : (raster.hpos[3:0] == 4'd0);

    always_comb begin
        char_addr_d = char_addr_q;
        if (border) begin
            char_addr_d = '0;
        end else if (start_active) begin
            char_addr_d = row_base;
        end else if (next_char) begin
            char_addr_d = char_addr_q + TAW'(1);
        end
    end

    always_ff @(posedge vclk) begin
        if (!rst_n) begin
            char_addr_q <= '0;
            border_q    <= 1'b1;
        end else begin
            char_addr_q <= char_addr_d;
            border_q    <= border;
        end
    end

    //////////////////////////////////////////////////
    // Text and glyph memories
    //////////////////////////////////////////////////
    assign tram_we  = cpu_wr.wren && (cpu_wr.target == TGT_TEXT);
    assign chram_we = cpu_wr.wren && (cpu_wr.target == TGT_GLYPH);

    dp_ram #(
        .ADDR_W (TAW),
        .DATA_W (16)
    ) u_text_ram (
        .vclk    (vclk),
        .wr_en   (tram_we),
        .wr_addr (cpu_wr.addr),
        .wr_data (cpu_wr.data),
        .rd_addr (char_addr_d),
        .rd_data (cell_q1)
    );

    // Char code then glyph row
    assign glyph_addr = {cell_q1[7:0], line_q1};

    dp_ram #(
        .ADDR_W (CAW),
        .DATA_W (8)
    ) u_glyph_ram (
        .vclk    (vclk),
        .wr_en   (chram_we),
        .wr_addr (cpu_wr.addr[CAW-1:0]),
        .wr_data (cpu_wr.data[7:0]),
        .rd_addr (glyph_addr),
        .rd_data (glyph_q2)
    );

    //////////////////////////////////////////////////
    // Pipeline alignment
    //////////////////////////////////////////////////
    always_ff @(posedge vclk) begin
        line_q1   <= raster.line[2:0];
        hpos_q1   <= raster.hpos[3:0];
        hpos_q2   <= hpos_q1;
        colour_q2 <= cell_q1[15:8];
    end

    // hsync, vsync, blank, border
    always_ff @(posedge vclk) begin
        if (!rst_n) begin
            ctl_q1 <= '0;
            ctl_q2 <= '0;
        end else begin
            ctl_q1 <= {raster.hsync, raster.vsync, raster.blank, raster.vborder};
            ctl_q2 <= ctl_q1;
        end
    end

    //////////////////////////////////////////////////
    // Pixel select
    //////////////////////////////////////////////////
    // 40 columns show each glyph bit twice
    assign pix_sel   = (col_mode == COLS_80) ? hpos_q2[2:0] : hpos_q2[3:1];
    assign glyph_bit = glyph_q2[~pix_sel];

    always_comb begin
        text_pix.colidx = glyph_bit ? colour_q2[7:4] : colour_q2[3:0];
        text_pix.hsync  = ctl_q2[3];
        text_pix.vsync  = ctl_q2[2];
        text_pix.blank  = ctl_q2[1];
        text_pix.border = ctl_q2[0];
    end

    // Mode latch only moves while vblank is up
    a_mode_in_vblank: assert property (
        @(posedge vclk) disable iff (!rst_n)
        !$stable(col_mode) |-> $past(raster.vblank)
    );

endmodule

// File: logic/pixel_output.sv
module pixel_output (
    input  logic                   vclk,
    input  logic                   rst_n,
    input  video_pkg::vtiming_t    raster,
    input  video_pkg::text_pixel_t text_pix,
    input  video_pkg::cpu_write_t  cpu_wr,
    input  logic [7:0]             irq_line_sel,
    output logic [3:0]             video_r,
    output logic [3:0]             video_g,
    output logic [3:0]             video_b,
    output logic                   video_de,
    output logic                   video_hsync,
    output logic                   video_vsync,
    output logic                   video_newframe,
    output logic                   irq_line,
    output logic                   irq_vblank
);
    import video_pkg::*;

    logic [11:0] palette [16];
    logic        pal_we;
    logic [3:0]  pal_idx;
    logic [11:0] pal_rgb;
    logic        line_match;
    logic        line_match_q;
    logic        vblank_q;

    //////////////////////////////////////////////////
    // Palette
    //////////////////////////////////////////////////
    assign pal_we = cpu_wr.wren && (cpu_wr.target == TGT_PALETTE);

    // Entry layout is R in bits 11..8, then G, then B
    always_ff @(posedge vclk) begin
        if (pal_we) begin
            palette[cpu_wr.addr[3:0]] <= cpu_wr.data[11:0];
        end
    end

    // Border is always entry 0
    assign pal_idx = text_pix.border ? 4'd0 : text_pix.colidx;
    assign pal_rgb = palette[pal_idx];

    //////////////////////////////////////////////////
    // Output registers
    //////////////////////////////////////////////////
    always_ff @(posedge vclk) begin
        if (!rst_n) begin
            video_r     <= '0;
            video_g     <= '0;
            video_b     <= '0;
            video_de    <= 1'b0;
            video_hsync <= 1'b0;
            video_vsync <= 1'b0;
        end else begin
            if (text_pix.blank) begin
                video_r  <= '0;
                video_g  <= '0;
                video_b  <= '0;
                video_de <= 1'b0;
            end else begin
                video_r  <= pal_rgb[11:8];
                video_g  <= pal_rgb[7:4];
                video_b  <= pal_rgb[3:0];
                video_de <= 1'b1;
            end
            video_hsync <= text_pix.hsync;
            video_vsync <= text_pix.vsync;
        end
    end

    //////////////////////////////////////////////////
    // Interrupt pulses
    //////////////////////////////////////////////////
    assign line_match = (raster.line == irq_line_sel);

    always_ff @(posedge vclk) begin
        if (!rst_n) begin
            line_match_q   <= 1'b0;
            vblank_q       <= 1'b0;
            irq_line       <= 1'b0;
            irq_vblank     <= 1'b0;
            video_newframe <= 1'b0;
        end else begin
            line_match_q   <= line_match;
            vblank_q       <= raster.vblank;
            // Rising edges only
            irq_line       <= line_match && !line_match_q;
            irq_vblank     <= raster.vblank && !vblank_q;
            video_newframe <= raster.newframe;
        end
    end

    // Active video ends before the sync pulse starts
    a_de_not_in_hsync: assert property (
        @(posedge vclk) disable iff (!rst_n)
        !(video_de && video_hsync)
    );

endmodule

// File: logic/video_top.sv
module video_top (
    input  logic                  vclk,
    input  logic                  rst_n,
    input  video_pkg::cpu_write_t cpu_wr,
    input  logic                  mode_80,
    input  logic [7:0]            irq_line_sel,
    output logic [3:0]            video_r,
    output logic [3:0]            video_g,
    output logic [3:0]            video_b,
    output logic                  video_de,
    output logic                  video_hsync,
    output logic                  video_vsync,
    output logic                  video_newframe,
    output logic                  irq_line,
    output logic                  irq_vblank
);
    import video_pkg::*;

    vtiming_t    raster;
    text_pixel_t text_pix;

    //////////////////////////////////////////////////
    // Raster timing
    //////////////////////////////////////////////////
    video_timing u_timing (
        .vclk   (vclk),
        .rst_n  (rst_n),
        .raster (raster)
    );

    //////////////////////////////////////////////////
    // Text and glyph fetch
    //////////////////////////////////////////////////
    // Each block picks its own write targets out of cpu_wr
    text_fetch u_text (
        .vclk     (vclk),
        .rst_n    (rst_n),
        .raster   (raster),
        .cpu_wr   (cpu_wr),
        .mode_80  (mode_80),
        .text_pix (text_pix)
    );

    //////////////////////////////////////////////////
    // Palette and VGA outputs
    //////////////////////////////////////////////////
    pixel_output u_output (
        .vclk           (vclk),
        .rst_n          (rst_n),
        .raster         (raster),
        .text_pix       (text_pix),
        .cpu_wr         (cpu_wr),
        .irq_line_sel   (irq_line_sel),
        .video_r        (video_r),
        .video_g        (video_g),
        .video_b        (video_b),
        .video_de       (video_de),
        .video_hsync    (video_hsync),
        .video_vsync    (video_vsync),
        .video_newframe (video_newframe),
        .irq_line       (irq_line),
        .irq_vblank     (irq_vblank)
    );

endmodule

// File: testbench/tb_video_tasks.svh
`ifndef TB_VIDEO_TASKS_SVH
`define TB_VIDEO_TASKS_SVH

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////
task automatic check_rgb(input string what, input logic [3:0] r, input logic [3:0] g,
                         input logic [3:0] b, input logic [3:0] er, input logic [3:0] eg,
                         input logic [3:0] eb);
    check_cnt++;
    if ({r, g, b} !== {er, eg, eb}) begin
        err_cnt++;
        $display("Fail video_r/g/b %s: got %h %h %h, expected %h %h %h",
                 what, r, g, b, er, eg, eb);
    end
endtask

task automatic check_count(input string what, input int got, input int expected);
    check_cnt++;
    if (got != expected) begin
        err_cnt++;
        $display("Fail %s: got %h, expected %h", what, got, expected);
    end
endtask

task automatic check_pulse(input string what, input int seen, input int expected);
    check_cnt++;
    if (seen < expected) begin
        err_cnt++;
        $display("Fail %s: pulse missing, got %h expected %h", what, seen, expected);
    end else if (seen > expected) begin
        err_cnt++;
        $display("Fail %s: extra pulse, got %h expected %h", what, seen, expected);
    end
endtask

task automatic end_test(input string name, input int errs_before);
    if (timed_out) begin
        $display("Test %s: stopped by a timeout", name);
    end else if (err_cnt == errs_before) begin
        $display("Test %s: ok", name);
    end else begin
        $display("Test %s: %0d errors", name, err_cnt - errs_before);
    end
endtask

//////////////////////////////////////////////////
// Waits, all bounded
//////////////////////////////////////////////////
task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    timed_out = 1'b1;
endtask

task automatic wait_newframe();
    int n;
    n = 0;
    @(negedge vclk);
    while (!video_newframe && !timed_out) begin
        @(negedge vclk);
        n++;
        if (n > FRAME_CYCLES) begin
            report_timeout("video_newframe never pulsed");
        end
    end
endtask

task automatic wait_hsync_rise();
    int n;
    n = 0;
    while (video_hsync && !timed_out) begin
        @(negedge vclk);
        n++;
        if (n > LINE_CYCLES) begin
            report_timeout("video_hsync stuck high");
        end
    end
    while (!video_hsync && !timed_out) begin
        @(negedge vclk);
        n++;
        if (n > LINE_CYCLES) begin
            report_timeout("video_hsync never rose");
        end
    end
endtask

// Returns on the first pixel of an active run
task automatic wait_de_rise();
    int n;
    n = 0;
    while (video_de && !timed_out) begin
        @(negedge vclk);
        n++;
        if (n > LINE_CYCLES) begin
            report_timeout("video_de stuck high");
        end
    end
    while (!video_de && !timed_out) begin
        @(negedge vclk);
        n++;
        if (n > LINE_CYCLES) begin
            report_timeout("video_de never rose");
        end
    end
endtask

task automatic skip_to_scan(input int scan);
    int k;
    wait_newframe();
    for (k = 0; k <= scan; k++) begin
        wait_de_rise();
    end
endtask

//////////////////////////////////////////////////
// CPU write drivers
//////////////////////////////////////////////////
task automatic cpu_write(input vid_target_e target, input logic [`TRAM_AW-1:0] addr,
                         input logic [15:0] data);
    @(negedge vclk);
    cpu_wr.target = target;
    cpu_wr.addr   = addr;
    cpu_wr.data   = data;
    cpu_wr.wren   = 1'b1;
    @(negedge vclk);
    cpu_wr.wren   = 1'b0;
endtask

task automatic load_palette();
    int          i;
    logic [31:0] v;
    for (i = 0; i < 16; i++) begin
        v = next_random();
        pal_model[4'(i)] = v[27:16];
        cpu_write(TGT_PALETTE, 11'(i), {4'h0, v[27:16]});
    end
endtask

// All 8 rows random, row 0 handed back for checking
task automatic load_glyph(input logic [7:0] code, output logic [7:0] row0);
    int          i;
    logic [31:0] v;
    row0 = '0;
    for (i = 0; i < 8; i++) begin
        v = next_random();
        if (i == 0) begin
            row0 = v[23:16];
        end
        cpu_write(TGT_GLYPH, {code, 3'(i)}, {8'h00, v[23:16]});
    end
endtask

// Width is the number of pixels that one glyph bit covers
task automatic check_cell_pixels(input string tag, input logic [7:0] row,
                                 input logic [7:0] colour, input int n_pix,
                                 input int width);
    int          p;
    logic [2:0]  bit_pos;
    logic [3:0]  idx;
    logic [11:0] exp_rgb;
    for (p = 0; p < n_pix && !timed_out; p++) begin
        // Leftmost pixel from the glyph MSB
        bit_pos = 3'(7 - p / width);
        idx     = row[bit_pos] ? colour[7:4] : colour[3:0];
        exp_rgb = pal_model[idx];
        check_rgb($sformatf("%s pixel %0d", tag, p), video_r, video_g, video_b,
                  exp_rgb[11:8], exp_rgb[7:4], exp_rgb[3:0]);
        @(negedge vclk);
    end
endtask

//////////////////////////////////////////////////
// Tests
//////////////////////////////////////////////////
task automatic reset_and_line_test();
    int   errs;
    int   period;
    int   hs_cnt;
    int   de_cnt;
    logic hs_prev;
    logic rise;
    errs  = err_cnt;
    rst_n = 1'b0;
    repeat (8) @(posedge vclk);
    @(negedge vclk);
    // Reset still applied here
    check_rgb("in reset", video_r, video_g, video_b, 4'h0, 4'h0, 4'h0);
    check_pulse("video_de", int'(video_de), 0);
    check_pulse("video_hsync", int'(video_hsync), 0);
    check_pulse("video_vsync", int'(video_vsync), 0);
    check_pulse("irq_line", int'(irq_line), 0);
    check_pulse("irq_vblank", int'(irq_vblank), 0);
    check_pulse("video_newframe", int'(video_newframe), 0);
    rst_n = 1'b1;

    // One full hsync period from rising edge to rising edge
    wait_hsync_rise();
    period = 0;
    hs_cnt = 1;
    de_cnt = 0;
    rise   = 1'b0;
    while (!rise && !timed_out) begin
        hs_prev = video_hsync;
        @(negedge vclk);
        period++;
        if (video_hsync && !hs_prev) begin
            rise = 1'b1;
        end else begin
            if (video_hsync) begin
                hs_cnt++;
            end
            if (video_de) begin
                de_cnt++;
            end
        end
        if (period > LINE_CYCLES) begin
            report_timeout("second video_hsync edge missing");
        end
    end
    if (!timed_out) begin
        check_count("video_hsync period", period, `H_TOTAL);
        check_count("video_hsync width", hs_cnt, `H_SYNC_LEN);
        check_count("video_de per line", de_cnt, `H_ACTIVE);
    end
    end_test("reset and line", errs);
endtask

task automatic text_pixel_test();
    int          errs;
    logic [31:0] v;
    errs = err_cnt;
    load_palette();
    load_glyph(8'h41, row0_41);
    v         = next_random();
    colour_41 = v[23:16];
    cpu_write(TGT_TEXT, 11'd0, {colour_41, 8'h41});
    skip_to_scan(TEXT_SCAN);
    check_cell_pixels("40 col", row0_41, colour_41, 16, 2);
    end_test("text pixels", errs);
endtask

task automatic border_test();
    int errs;
    int scan;
    int n;
    int total;
    errs  = err_cnt;
    total = 0;
    wait_newframe();
    for (scan = 0; scan < TEXT_SCAN; scan++) begin
        wait_de_rise();
        n = 0;
        while (video_de && !timed_out && n < `H_TOTAL) begin
            check_rgb("border", video_r, video_g, video_b,
                      pal_model[0][11:8], pal_model[0][7:4], pal_model[0][3:0]);
            n++;
            @(negedge vclk);
        end
        total += n;
    end
    if (!timed_out) begin
        check_count("video_de border pixels", total, TEXT_SCAN * `H_ACTIVE);
    end
    end_test("border", errs);
endtask

task automatic column_mode_test();
    int          errs;
    logic [31:0] v;
    logic [7:0]  row0_42;
    logic [7:0]  colour_42;
    errs = err_cnt;
    load_glyph(8'h42, row0_42);
    v         = next_random();
    colour_42 = v[23:16];
    cpu_write(TGT_TEXT, 11'd1, {colour_42, 8'h42});
    // Picked up at the coming vblank
    mode_80 = 1'b1;
    skip_to_scan(TEXT_SCAN);
    check_cell_pixels("80 col cell 0", row0_41, colour_41, 8, 1);
    check_cell_pixels("80 col cell 1", row0_42, colour_42, 8, 1);
    mode_80 = 1'b0;
    end_test("column mode", errs);
endtask

task automatic interrupt_test();
    int errs;
    int n;
    int line_pulses;
    int vbl_pulses;
    int vs_cycles;
    errs         = err_cnt;
    irq_line_sel = 8'd100;
    n            = 0;
    line_pulses  = 0;
    vbl_pulses   = 0;
    vs_cycles    = 0;
    wait_newframe();
    @(negedge vclk);
    // High cycles per frame, so a stretched pulse counts as extra
    while (!video_newframe && !timed_out) begin
        if (irq_line) begin
            line_pulses++;
        end
        if (irq_vblank) begin
            vbl_pulses++;
        end
        if (video_vsync) begin
            vs_cycles++;
        end
        @(negedge vclk);
        n++;
        if (n > FRAME_CYCLES) begin
            report_timeout("second video_newframe pulse missing");
        end
    end
    if (!timed_out) begin
        check_pulse("irq_line", line_pulses, 1);
        check_pulse("irq_vblank", vbl_pulses, 1);
        // Sync spans whole scan lines
        check_count("video_vsync high cycles", vs_cycles, `V_SYNC_LEN * `H_TOTAL);
    end
    end_test("interrupts", errs);
endtask

`endif

// File: testbench/tb_video.sv
`include "video_config.svh"

module tb_video;
    timeunit 1ns;
    timeprecision 1ps;

    import video_pkg::*;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL + 100;
    localparam int LINE_CYCLES  = 2 * `H_TOTAL;
    // First scan line of the text area
    localparam int TEXT_SCAN    = 2 * `BORDER_TOP;

    logic        vclk = 1'b0;
    logic        rst_n;
    cpu_write_t  cpu_wr;
    logic        mode_80;
    logic [7:0]  irq_line_sel;
    logic [3:0]  video_r;
    logic [3:0]  video_g;
    logic [3:0]  video_b;
    logic        video_de;
    logic        video_hsync;
    logic        video_vsync;
    logic        video_newframe;
    logic        irq_line;
    logic        irq_vblank;

    int          check_cnt;
    int          err_cnt;
    logic        timed_out;
    logic [31:0] lcg_state;
    // Expected palette contents, R G B nibbles
    logic [11:0] pal_model [16];
    logic [7:0]  row0_41;
    logic [7:0]  colour_41;

    always #5 vclk = ~vclk;

    video_top DUT (
        .vclk           (vclk),
        .rst_n          (rst_n),
        .cpu_wr         (cpu_wr),
        .mode_80        (mode_80),
        .irq_line_sel   (irq_line_sel),
        .video_r        (video_r),
        .video_g        (video_g),
        .video_b        (video_b),
        .video_de       (video_de),
        .video_hsync    (video_hsync),
        .video_vsync    (video_vsync),
        .video_newframe (video_newframe),
        .irq_line       (irq_line),
        .irq_vblank     (irq_vblank)
    );

    // Numerical Recipes LCG constants
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    `include "tb_video_tasks.svh"

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        cpu_wr       = '0;
        mode_80      = 1'b0;
        irq_line_sel = 8'd100;
        rst_n        = 1'b0;
        check_cnt    = 0;
        err_cnt      = 0;
        timed_out    = 1'b0;
        lcg_state    = 32'h2fc99b9a;

        reset_and_line_test();
        text_pixel_test();
        border_test();
        column_mode_test();
        interrupt_test();

        $display("Summary: %0d checks, %0d errors, timeout %0d", check_cnt, err_cnt,
                 timed_out);
        if (err_cnt == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+logic
+incdir+testbench
logic/video_pkg.sv
logic/dp_ram.sv
logic/video_timing.sv
logic/text_fetch.sv
logic/pixel_output.sv
logic/video_top.sv
testbench/tb_video.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build tb_video with Verilator, run it, check $(LOG)"
	@echo "  make clean  remove obj_dir and $(LOG)"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_video -f compile.f -o tb_video
	./obj_dir/tb_video | tee $(LOG)
	@grep -q "^TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
